/* build.f */
source/mem_pkg.sv
source/cache_array.sv
source/banked_memory.sv
source/cache_controller.sv
source/mem_system.sv
verification/mem_system_sva.sv
verification/mem_system_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the memory system testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module mem_system_tb -f build.f -o mem_system_sim

./obj_dir/mem_system_sim > sim.log 2>&1 || echo "Simulation exited with an error status"
cat sim.log

if grep -q "^TESTS PASSED$" sim.log; then
   exit 0
else
   exit 1
fi

/* verification/mem_system_golden.txt */
// op (1 read, 2 write, 3 both)  addr  write_data  expected_data  expected_hit  expected_err
// All fields hex, expected data is checked on error-free reads only
1 0010 0000 0000 0 0
1 0010 0000 0000 1 0
2 0102 a5a5 0000 0 0
1 0102 0000 a5a5 1 0
1 0106 0000 0000 1 0
2 0100 1234 0000 1 0
1 0900 0000 0000 0 0
1 0102 0000 a5a5 0 0
1 0100 0000 1234 1 0
1 0103 0000 0000 0 1
2 0105 ffff 0000 0 1
3 0104 beef 0000 0 1
1 0104 0000 0000 1 0
1 0102 0000 a5a5 1 0
2 1200 1111 0000 0 0
2 1a0a 2222 0000 0 0
2 1214 3333 0000 0 0
1 1a00 0000 0000 0 0
1 1208 0000 0000 0 0
1 1a14 0000 0000 0 0
1 1200 0000 1111 0 0
1 1a0a 0000 2222 0 0
1 1214 0000 3333 0 0
1 1216 0000 0000 1 0

/* verification/mem_system_tb.sv */
//##########################################################
// Memory system testbench
// Replays the golden request list through the cached memory
// and checks data, hit, error flag and done latency
//##########################################################
`timescale 1ns/1ps

module mem_system_tb;

   localparam int max_req     = 64;
   localparam int wdog_cycles = 200;    // Per request

   logic        clk;
   logic        rst_n;
   logic [15:0] addr;
   logic [15:0] data_in;
   logic        rd;
   logic        wr;
   logic [15:0] data_out;
   logic        done;
   logic        stall;
   logic        cache_hit;
   logic        err;

   // Golden table, one entry per request
   logic [1:0]  op_q     [max_req];   // Bit 0 read, bit 1 write
   logic [15:0] addr_q   [max_req];
   logic [15:0] wdata_q  [max_req];
   logic [15:0] exp_data [max_req];
   logic        exp_hit  [max_req];
   logic        exp_err  [max_req];
   int          num_req;
   int          fail_cnt;
   logic        loaded;

   mem_system dut_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   always #2 clk = ~clk;

   task automatic load_golden();
      int          fd;
      string       line;
      logic [15:0] f_op, f_addr, f_wdata, f_data, f_hit, f_err;
      fd = $fopen("verification/mem_system_golden.txt", "r");
      if (fd == 0) begin
         $display("Could not open the golden file");
         fail_cnt++;
         return;
      end
      // Comment and blank lines do not scan as six fields
      while ($fgets(line, fd) != 0 && num_req < max_req) begin
         if ($sscanf(line, "%h %h %h %h %h %h", f_op, f_addr, f_wdata, f_data, f_hit,
                     f_err) == 6) begin
            op_q[num_req]     = f_op[1:0];
            addr_q[num_req]   = f_addr;
            wdata_q[num_req]  = f_wdata;
            exp_data[num_req] = f_data;
            exp_hit[num_req]  = f_hit[0];
            exp_err[num_req]  = f_err[0];
            num_req++;
         end
      end
      $fclose(fd);
   endtask

   task automatic run_request(input int n);
      int   lat;
      logic bad;
      logic stall_low;
      lat       = 0;
      bad       = 1'b0;
      stall_low = 1'b0;
      @(posedge clk);
      addr    <= addr_q[n];
      data_in <= wdata_q[n];
      rd      <= op_q[n][0];
      wr      <= op_q[n][1];
      @(negedge clk);                     // Middle of the request cycle
      if (stall !== 1'b0) begin
         $display("Error: req %0d stall = 0x%h in the request cycle, expected 0x0", n, stall);
         bad = 1'b1;
      end
      while (!done) begin
         @(negedge clk);
         lat++;
         // Busy from the cycle after the request through done
         if (stall !== 1'b1 && !stall_low) begin
            $display("Error: req %0d stall = 0x%h before done, expected 0x1", n, stall);
            stall_low = 1'b1;
            bad       = 1'b1;
         end
      end
      if (err !== exp_err[n]) begin
         $display("Error: req %0d err = 0x%h, expected 0x%h", n, err, exp_err[n]);
         bad = 1'b1;
      end
      if (cache_hit !== exp_hit[n]) begin
         $display("Error: req %0d cache_hit = 0x%h, expected 0x%h", n, cache_hit, exp_hit[n]);
         bad = 1'b1;
      end
      if (op_q[n] == 2'd1 && !exp_err[n] && data_out !== exp_data[n]) begin
         $display("Error: req %0d data_out = 0x%h, expected 0x%h", n, data_out, exp_data[n]);
         bad = 1'b1;
      end
      if (exp_err[n] && lat != 1) begin
         $display("Request %0d gave its error after %0d cycles instead of 1", n, lat);
         bad = 1'b1;
      end
      if (!exp_err[n] && exp_hit[n] && lat != 2) begin
         $display("Request %0d hit but took %0d cycles instead of 2", n, lat);
         bad = 1'b1;
      end
      @(posedge clk);
      rd <= 1'b0;
      wr <= 1'b0;
      if (bad) fail_cnt++;
      $display("req %0d op %0d addr 0x%h latency %0d: %s", n, op_q[n], addr_q[n], lat,
               bad ? "failed" : "ok");
   endtask

   initial begin
      clk      = 1'b0;
      rst_n    = 1'b0;
      addr     = '0;
      data_in  = '0;
      rd       = 1'b0;
      wr       = 1'b0;
      num_req  = 0;
      fail_cnt = 0;
      loaded   = 1'b0;
      load_golden();
      loaded = 1'b1;
      if (num_req == 0) begin
         $display("No requests found in the golden file");
         fail_cnt++;
      end
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      for (int n = 0; n < num_req; n++) begin
         run_request(n);
      end
      $display("%0d requests run, %0d failed", num_req, fail_cnt);
      if (fail_cnt == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

   // Watchdog scaled by the number of requests
   initial begin
      wait (loaded);
      repeat ((num_req + 1) * wdog_cycles) @(posedge clk);
      $display("Timeout, a request never finished with done");
      $display("TESTS FAILED");
      $finish;
   end

endmodule

/* verification/mem_system_sva.sv */
//##########################################################
// Memory system assertions
// Handshake and error checks bound into the top level
//##########################################################
`timescale 1ns/1ps

module mem_system_sva (
   input logic clk,
   input logic rst_n,
   input logic done,
   input logic stall,
   input logic err,
   input logic mem_wr,
   input logic mem_rd
);

   // Done is a single-cycle pulse
   done_pulse_a: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
      else $error("done stayed high for two cycles");

   stall_after_done_a: assert property (@(posedge clk) disable iff (!rst_n) done |=> !stall)
      else $error("stall high in the cycle after done");

   mem_cmd_a: assert property (@(posedge clk) disable iff (!rst_n) !(mem_wr && mem_rd))
      else $error("memory read and write issued together");

   err_done_a: assert property (@(posedge clk) disable iff (!rst_n) err |-> done)
      else $error("err raised outside a done cycle");

endmodule

bind mem_system mem_system_sva mem_system_sva_i (
   .clk    (clk),
   .rst_n  (rst_n),
   .done   (done),
   .stall  (stall),
   .err    (err),
   .mem_wr (m_wr),
   .mem_rd (m_rd)
);

/* source/mem_system.sv */
//##########################################################
// Cached memory system top level
// Direct-mapped write-back cache in front of the banked
// main memory, with a Stall/Done requester interface
//##########################################################
`timescale 1ns/1ps

module mem_system (
   input  logic        clk,
   input  logic        rst_n,
   input  logic [15:0] addr,
   input  logic [15:0] data_in,
   input  logic        rd,
   input  logic        wr,
   output logic [15:0] data_out,
   output logic        done,
   output logic        stall,
   output logic        cache_hit,
   output logic        err
);

   mem_pkg::mem_addr_u req_addr;

   logic [mem_pkg::tag_w-1:0]    tag_out;
   logic [mem_pkg::offset_w-1:0] word_offset;
   logic [15:0] c_data_in;
   logic [15:0] c_data_out;
   logic [15:0] m_data_out;
   logic [15:0] m_addr;
   logic        hit;
   logic        dirty;
   logic        valid;
   logic        enable;
   logic        comp;
   logic        write;
   logic        valid_in;
   logic        fill_select;
   logic        m_wr;
   logic        m_rd;
   logic        m_stall;

   assign req_addr = addr;

   // Fill data from memory, otherwise requester data
   assign c_data_in = fill_select ? m_data_out : data_in;
   assign data_out  = c_data_out;

   cache_array cache_array_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .enable   (enable),
      .comp     (comp),
      .write    (write),
      .valid_in (valid_in),
      .index    (req_addr.cache.index),
      .offset   (word_offset),
      .tag_in   (req_addr.cache.tag),
      .data_in  (c_data_in),
      .tag_out  (tag_out),
      .data_out (c_data_out),
      .hit      (hit),
      .dirty    (dirty),
      .valid    (valid)
   );

   cache_controller cache_controller_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .addr         (addr),
      .rd           (rd),
      .wr           (wr),
      .hit          (hit),
      .dirty        (dirty),
      .valid        (valid),
      .tag_out      (tag_out),
      .mem_data_out (m_data_out),
      .mem_stall    (m_stall),
      .done         (done),
      .stall        (stall),
      .cache_hit    (cache_hit),
      .err          (err),
      .enable       (enable),
      .comp         (comp),
      .write        (write),
      .valid_in     (valid_in),
      .word_offset  (word_offset),
      .fill_select  (fill_select),
      .mem_addr     (m_addr),
      .mem_wr       (m_wr),
      .mem_rd       (m_rd)
   );

   banked_memory banked_memory_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .mem_addr     (m_addr),
      .mem_data_in  (c_data_out),   // Victim word during write-back
      .mem_wr       (m_wr),
      .mem_rd       (m_rd),
      .mem_data_out (m_data_out),
      .mem_stall    (m_stall)
   );

endmodule

/* source/cache_controller.sv */
//##########################################################
// Cache controller FSM
// Handles hits, dirty line write-back and a pipelined line
// fill, then repeats the compare so writes merge
//##########################################################
`timescale 1ns/1ps

module cache_controller (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic [15:0]                  addr,
   input  logic                         rd,
   input  logic                         wr,
   input  logic                         hit,
   input  logic                         dirty,
   input  logic                         valid,
   input  logic [mem_pkg::tag_w-1:0]    tag_out,
   input  logic [15:0]                  mem_data_out,
   input  logic                         mem_stall,
   output logic                         done,
   output logic                         stall,
   output logic                         cache_hit,
   output logic                         err,
   output logic                         enable,
   output logic                         comp,
   output logic                         write,
   output logic                         valid_in,
   output logic [mem_pkg::offset_w-1:0] word_offset,
   output logic                         fill_select,
   output logic [15:0]                  mem_addr,
   output logic                         mem_wr,
   output logic                         mem_rd
);

   localparam int lat = mem_pkg::mem_read_latency;

   mem_pkg::ctrl_state_t state;
   mem_pkg::ctrl_state_t state_nxt;
   mem_pkg::mem_addr_u   req_addr;
   mem_pkg::mem_addr_u   line_addr;

   logic                       req_wr;      // Latched operation
   logic                       err_q;
   logic                       hit_q;
   logic                       first_cmp;
   logic [mem_pkg::word_w-1:0] wb_cnt;
   logic [mem_pkg::word_w-1:0] issue_cnt;
   logic [lat-1:0]             ret_vld;
   logic [mem_pkg::word_w-1:0] ret_word [lat];
   logic                       req_valid;
   logic                       req_bad;
   logic                       fill_take;
   logic                       ret_now;
   logic [mem_pkg::word_w-1:0] ret_tail;
   logic [mem_pkg::word_w-1:0] last_idx;

   assign req_addr  = addr;
   assign req_valid = rd | wr;
   assign req_bad   = (rd & wr) | req_addr.cache.offset[0];   // Conflict or odd address
   assign fill_take = mem_rd & ~mem_stall;
   assign ret_now   = ret_vld[lat-1];
   assign ret_tail  = ret_word[lat-1];
   assign last_idx  = mem_pkg::word_w'(mem_pkg::words_per_line - 1);

   assign done      = (state == mem_pkg::finish);
   assign stall     = (state != mem_pkg::idle);
   assign err       = done & err_q;
   assign cache_hit = done & hit_q;
   assign mem_addr  = line_addr;

   // Track which word of the fill comes back each cycle
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ret_vld <= '0;
      end else begin
         ret_vld <= {ret_vld[lat-2:0], fill_take};
      end
   end

   always_ff @(posedge clk) begin
      ret_word[0] <= issue_cnt;
      for (int i = 1; i < lat; i++) begin
         ret_word[i] <= ret_word[i-1];
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= mem_pkg::idle;
         req_wr    <= 1'b0;
         err_q     <= 1'b0;
         hit_q     <= 1'b0;
         first_cmp <= 1'b0;
         wb_cnt    <= '0;
         issue_cnt <= '0;
      end else begin
         state <= state_nxt;
         case (state)
            mem_pkg::idle: begin
               if (req_valid) begin
                  req_wr    <= wr;
                  err_q     <= req_bad;
                  hit_q     <= 1'b0;
                  first_cmp <= 1'b1;
                  wb_cnt    <= '0;
                  issue_cnt <= '0;
               end
            end
            mem_pkg::compare: begin
               first_cmp <= 1'b0;
               if (first_cmp) hit_q <= hit;   // Second compare never counts
            end
            mem_pkg::write_back: if (!mem_stall) wb_cnt <= wb_cnt + 1'b1;
            mem_pkg::fill_issue: if (!mem_stall) issue_cnt <= issue_cnt + 1'b1;
            default: ;
         endcase
      end
   end

   always_comb begin
      state_nxt = state;
      case (state)
         mem_pkg::idle: begin
            if (req_valid) state_nxt = req_bad ? mem_pkg::finish : mem_pkg::compare;
         end
         mem_pkg::compare: begin
            if (hit) state_nxt = mem_pkg::finish;
            else if (dirty && valid) state_nxt = mem_pkg::write_back;
            else state_nxt = mem_pkg::fill_issue;
         end
         mem_pkg::write_back: begin
            if (!mem_stall && wb_cnt == last_idx) state_nxt = mem_pkg::fill_issue;
         end
         mem_pkg::fill_issue: begin
            if (!mem_stall && issue_cnt == last_idx) state_nxt = mem_pkg::fill_wait;
         end
         mem_pkg::fill_wait: begin
            // Last word lands next cycle
            if (ret_vld[lat-2] && ret_word[lat-2] == last_idx) state_nxt = mem_pkg::install;
         end
         mem_pkg::install: state_nxt = mem_pkg::compare;
         mem_pkg::finish:  state_nxt = mem_pkg::idle;
         default:          state_nxt = mem_pkg::idle;
      endcase
   end

   always_comb begin
      enable      = 1'b0;
      comp        = 1'b0;
      write       = 1'b0;
      valid_in    = 1'b0;
      fill_select = 1'b0;
      mem_wr      = 1'b0;
      mem_rd      = 1'b0;
      word_offset = req_addr.cache.offset;
      line_addr   = req_addr;
      line_addr.cache.offset = {issue_cnt, 1'b0};
      case (state)
         mem_pkg::compare: begin
            enable = 1'b1;
            comp   = 1'b1;
            write  = req_wr;
         end
         mem_pkg::write_back: begin
            enable      = 1'b1;            // Read victim word
            word_offset = {wb_cnt, 1'b0};
            line_addr.cache.tag    = tag_out;
            line_addr.cache.offset = {wb_cnt, 1'b0};
            mem_wr      = 1'b1;
         end
         mem_pkg::fill_issue, mem_pkg::fill_wait, mem_pkg::install: begin
            mem_rd      = (state == mem_pkg::fill_issue);
            enable      = ret_now;
            write       = ret_now;
            fill_select = ret_now;
            word_offset = {ret_tail, 1'b0};
            valid_in    = ret_now && (ret_tail == last_idx);
         end
         mem_pkg::finish: begin
            enable = 1'b1;                 // Present the word on data_out
            comp   = 1'b1;
         end
         default: ;
      endcase
   end

endmodule

/* source/banked_memory.sv */
//##########################################################
// Four-bank interleaved main memory
// Per-bank busy timers with stall, and read data returned
// through a fixed-latency pipeline so banks can overlap
//##########################################################
`timescale 1ns/1ps

module banked_memory (
   input  logic        clk,
   input  logic        rst_n,
   input  logic [15:0] mem_addr,
   input  logic [15:0] mem_data_in,
   input  logic        mem_wr,
   input  logic        mem_rd,
   output logic [15:0] mem_data_out,
   output logic        mem_stall
);

   mem_pkg::mem_addr_u dec_addr;

   logic [mem_pkg::bank_w-1:0] bank_sel;
   logic [mem_pkg::row_w-1:0]  row_sel;
   logic [mem_pkg::busy_w-1:0] busy_cnt [mem_pkg::num_banks];
   logic [15:0]                bank_mem [mem_pkg::num_banks][mem_pkg::bank_rows];
   logic [15:0]                rd_pipe  [mem_pkg::mem_read_latency];
   logic                       access;
   logic                       accept;

   assign dec_addr = mem_addr;
   assign bank_sel = dec_addr.mem.bank;   // Low word bits pick the bank
   assign row_sel  = dec_addr.mem.row;

   assign access    = mem_rd | mem_wr;
   assign mem_stall = access & (busy_cnt[bank_sel] != '0);
   assign accept    = access & ~mem_stall;

   assign mem_data_out = rd_pipe[mem_pkg::mem_read_latency-1];

   // Power-up contents are zero
   initial begin
      for (int b = 0; b < mem_pkg::num_banks; b++) begin
         for (int r = 0; r < mem_pkg::bank_rows; r++) begin
            bank_mem[b][r] = '0;
         end
      end
   end

   always @(posedge clk) begin
      if (accept && mem_wr) begin
         bank_mem[bank_sel][row_sel] <= mem_data_in;
      end
   end

   // Busy timer per bank, loaded on every accepted access
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int b = 0; b < mem_pkg::num_banks; b++) begin
            busy_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < mem_pkg::num_banks; b++) begin
            if (accept && bank_sel == mem_pkg::bank_w'(b)) begin
               busy_cnt[b] <= mem_pkg::busy_w'(mem_pkg::bank_busy_cycles - 1);
            end else if (busy_cnt[b] != '0) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
         end
      end
   end

   // Read data pipeline, one stage per latency cycle
   always_ff @(posedge clk) begin
      if (accept && mem_rd) begin
         rd_pipe[0] <= bank_mem[bank_sel][row_sel];
      end
      for (int s = 1; s < mem_pkg::mem_read_latency; s++) begin
         rd_pipe[s] <= rd_pipe[s-1];
      end
   end

endmodule

/* source/cache_array.sv */
//##########################################################
// Direct-mapped cache storage
// Tag, valid, dirty and four data words per line, with a
// combinational read and compare or fill writes
//##########################################################
`timescale 1ns/1ps

module cache_array (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         enable,
   input  logic                         comp,
   input  logic                         write,
   input  logic                         valid_in,
   input  logic [mem_pkg::index_w-1:0]  index,
   input  logic [mem_pkg::offset_w-1:0] offset,
   input  logic [mem_pkg::tag_w-1:0]    tag_in,
   input  logic [15:0]                  data_in,
   output logic [mem_pkg::tag_w-1:0]    tag_out,
   output logic [15:0]                  data_out,
   output logic                         hit,
   output logic                         dirty,
   output logic                         valid
);

   logic [mem_pkg::tag_w-1:0] tag_mem  [mem_pkg::num_lines];
   logic [15:0]               data_mem [mem_pkg::num_lines][mem_pkg::words_per_line];
   logic [mem_pkg::num_lines-1:0] valid_bits;
   logic [mem_pkg::num_lines-1:0] dirty_bits;

   logic [mem_pkg::word_w-1:0] word_sel;
   logic                       tag_match;
   logic                       last_word;
   logic                       cmp_write;
   logic                       fill_write;

   // Byte bit is not part of the word select
   assign word_sel = offset[mem_pkg::offset_w-1:1];

   assign tag_out  = tag_mem[index];
   assign data_out = data_mem[index][word_sel];
   assign valid    = valid_bits[index];
   assign dirty    = dirty_bits[index];

   assign tag_match = (tag_mem[index] == tag_in);
   assign hit       = enable & comp & valid & tag_match;

   // Compare write lands only on a hit
   assign cmp_write  = hit & write;
   assign fill_write = enable & ~comp & write;   // Unconditional line fill
   assign last_word  = (word_sel == mem_pkg::word_w'(mem_pkg::words_per_line - 1));

   always_ff @(posedge clk) begin
      if (cmp_write || fill_write) begin
         data_mem[index][word_sel] <= data_in;
      end
      // New tag goes in with the final word of the line
      if (fill_write && last_word) begin
         tag_mem[index] <= tag_in;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_bits <= '0;
         dirty_bits <= '0;
      end else if (fill_write && last_word) begin
         valid_bits[index] <= valid_in;
         dirty_bits[index] <= 1'b0;                // Freshly filled line is clean
      end else if (cmp_write) begin
         dirty_bits[index] <= 1'b1;
      end
   end

endmodule

/* source/mem_pkg.sv */
//##########################################################
// Memory system package
// Cache and bank geometry, the shared address word with its
// cache and memory views, and the controller state encoding
//##########################################################
package mem_pkg;

   // Cache geometry
   localparam int tag_w          = 5;
   localparam int index_w        = 8;
   localparam int offset_w       = 3;
   localparam int words_per_line = 4;
   localparam int word_w         = $clog2(words_per_line);
   localparam int num_lines      = 1 << index_w;

   // Banked memory geometry and timing
   localparam int num_banks        = 4;
   localparam int bank_w           = $clog2(num_banks);
   localparam int bank_busy_cycles = 4;    // Includes the access cycle
   localparam int busy_w           = $clog2(bank_busy_cycles);
   localparam int mem_read_latency = 2;
   localparam int word_addr_w      = 15;
   localparam int row_w            = word_addr_w - bank_w;
   localparam int bank_rows        = 1 << row_w;

   // Same 16-bit address, split for the cache or for the banks
   typedef union packed {
      struct packed {
         logic [tag_w-1:0]    tag;
         logic [index_w-1:0]  index;
         logic [offset_w-1:0] offset;
      } cache;
      struct packed {
         logic [row_w-1:0]  row;          // Upper word address bits
         logic [bank_w-1:0] bank;         // Low word address bits
         logic              byte_sel;
      } mem;
   } mem_addr_u;

   typedef enum logic [2:0] {
      idle,
      compare,
      write_back,
      fill_issue,
      fill_wait,
      install,
      finish
   } ctrl_state_t;

endpackage
